//--- Makefile
VERILATOR  ?= verilator
TOP        ?= mem_stage_tb
RTL_TOP    ?= mem_stage_top
FILELIST   ?= build.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= Done: no errors
VFLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# the run passes only when the log holds the pass line.
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

lint_rtl:
	$(VERILATOR) --lint-only -Wall $(filter-out tests/%,$(shell grep -v '^+' $(FILELIST))) \
		--top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
+incdir+tests
common/mem_stage_pkg.sv
common/mem_bus_if.sv
load_store/load_store_align.sv
load_store/align_check.sv
src/data_ram.sv
src/mem_writeback.sv
src/mem_stage_top.sv
tests/mem_stage_tb.sv

//--- common/mem_bus_if.sv
`timescale 1ns/1ps

interface mem_bus_if;
    import mem_stage_pkg::*;

    // word selected in the data ram.
    ram_index_t word_index;
    // byte lanes written on a store.
    lane_mask_t lane_mask;
    // store data, already shifted onto its lanes.
    word_t      write_data;
    // addressed word, read combinationally.
    word_t      read_data;

    modport align (
        output word_index,
        output lane_mask,
        output write_data,
        input  read_data
    );

    modport ram (
        input  word_index,
        input  lane_mask,
        input  write_data,
        output read_data
    );

endinterface

//--- common/mem_stage_pkg.sv
package mem_stage_pkg;

    // one data word, used for register operands, ram data and load results.
    typedef logic [31:0] word_t;

    // byte address.
    typedef logic [31:0] addr_t;

    // one write enable per byte lane, bit 0 is the lowest byte.
    typedef logic [3:0] lane_mask_t;

    // data ram depth in words.
    localparam int RAM_WORDS = 64;

    // word index width, taken from address bits 7 to 2.
    localparam int RAM_ADDR_W = 6;

    typedef logic [RAM_ADDR_W-1:0] ram_index_t;

    // load modes.
    typedef enum logic [2:0] {
        MEM_READ_NONE        = 3'd0,
        MEM_READ_BYTE        = 3'd1,
        MEM_READ_UNSIGN_BYTE = 3'd2,
        MEM_READ_HALF        = 3'd3,
        MEM_READ_UNSIGN_HALF = 3'd4,
        MEM_READ_WORD        = 3'd5,
        MEM_READ_LWL         = 3'd6,
        MEM_READ_LWR         = 3'd7
    } mem_read_t;

    // store modes.
    typedef enum logic [2:0] {
        MEM_WRITE_NONE = 3'd0,
        MEM_WRITE_BYTE = 3'd1,
        MEM_WRITE_HALF = 3'd2,
        MEM_WRITE_WORD = 3'd3,
        MEM_WRITE_SWL  = 3'd4,
        MEM_WRITE_SWR  = 3'd5
    } mem_write_t;

endpackage

//--- load_store/align_check.sv
`timescale 1ns/1ps

module align_check (
    input  logic                      valid,
    input  mem_stage_pkg::mem_read_t  read_mode,
    input  mem_stage_pkg::mem_write_t write_mode,
    input  mem_stage_pkg::addr_t      addr,
    output logic                      misaligned,
    output logic                      write_enable
);
    import mem_stage_pkg::*;

    logic half_access;
    logic word_access;
    logic store_access;

    // access size from either mode.
    // byte and unaligned word modes have no alignment rule.
    always_comb begin
        half_access = 1'b0;
        word_access = 1'b0;
        case (read_mode)
            MEM_READ_HALF,
            MEM_READ_UNSIGN_HALF: half_access = 1'b1;
            MEM_READ_WORD:        word_access = 1'b1;
            default: ;
        endcase
        case (write_mode)
            MEM_WRITE_HALF: half_access = 1'b1;
            MEM_WRITE_WORD: word_access = 1'b1;
            default: ;
        endcase
    end

    assign store_access = (write_mode != MEM_WRITE_NONE);

    assign misaligned = (half_access & addr[0]) | (word_access & (|addr[1:0]));

    // a faulting store never reaches the ram.
    assign write_enable = valid & store_access & ~misaligned;

endmodule

//--- load_store/load_store_align.sv
`timescale 1ns/1ps

module load_store_align (
    input  mem_stage_pkg::mem_read_t  read_mode,
    input  mem_stage_pkg::mem_write_t write_mode,
    input  mem_stage_pkg::addr_t      addr,
    input  mem_stage_pkg::word_t      register_data,
    mem_bus_if.align                  bus,
    output mem_stage_pkg::word_t      load_result
);
    import mem_stage_pkg::*;

    logic [1:0]  offset;
    // bit shift for the byte offset, offset * 8.
    logic [4:0]  lane_shift;
    // bit shift for the complement, (3 - offset) * 8.
    logic [4:0]  upper_shift;
    logic [4:0]  half_shift;
    logic [7:0]  load_byte;
    logic [15:0] load_half;

    assign offset      = addr[1:0];
    assign lane_shift  = {offset, 3'b000};
    assign upper_shift = {~offset, 3'b000};
    assign half_shift  = {offset[1], 4'b0000};

    assign bus.word_index = addr[RAM_ADDR_W+1:2];

    assign load_byte = bus.read_data[lane_shift +: 8];
    assign load_half = bus.read_data[half_shift +: 16];

    // load extraction and merging.
    always_comb begin
        case (read_mode)
            MEM_READ_BYTE:
                load_result = {{24{load_byte[7]}}, load_byte};
            MEM_READ_UNSIGN_BYTE:
                load_result = {24'd0, load_byte};
            MEM_READ_HALF: begin
                if (offset[0]) begin
                    load_result = '0;
                end else begin
                    load_result = {{16{load_half[15]}}, load_half};
                end
            end
            MEM_READ_UNSIGN_HALF: begin
                if (offset[0]) begin
                    load_result = '0;
                end else begin
                    load_result = {16'd0, load_half};
                end
            end
            MEM_READ_WORD: begin
                if (|offset) begin
                    load_result = '0;
                end else begin
                    load_result = bus.read_data;
                end
            end
            // ram bytes up to the offset fill the top of the register.
            MEM_READ_LWL:
                load_result = (register_data & ~(32'hffff_ffff << upper_shift))
                            | (bus.read_data << upper_shift);
            // ram bytes from the offset up fill the bottom of the register.
            MEM_READ_LWR:
                load_result = (register_data & ~(32'hffff_ffff >> lane_shift))
                            | (bus.read_data >> lane_shift);
            default:
                load_result = '0;
        endcase
    end

    // store lane mask and data placement.
    always_comb begin
        case (write_mode)
            MEM_WRITE_BYTE: begin
                bus.lane_mask  = 4'b0001 << offset;
                bus.write_data = register_data << lane_shift;
            end
            MEM_WRITE_HALF: begin
                bus.lane_mask  = offset[1] ? 4'b1100 : 4'b0011;
                bus.write_data = register_data << half_shift;
            end
            MEM_WRITE_WORD: begin
                bus.lane_mask  = 4'b1111;
                bus.write_data = register_data;
            end
            // lanes 0 up to the offset take the top register bytes.
            MEM_WRITE_SWL: begin
                bus.lane_mask  = 4'b1111 >> ~offset;
                bus.write_data = register_data >> upper_shift;
            end
            // lanes from the offset up take the low register bytes.
            MEM_WRITE_SWR: begin
                bus.lane_mask  = 4'b1111 << offset;
                bus.write_data = register_data << lane_shift;
            end
            default: begin
                bus.lane_mask  = '0;
                bus.write_data = '0;
            end
        endcase
    end

endmodule

//--- src/data_ram.sv
`timescale 1ns/1ps

module data_ram (
    input  logic  clk,
    mem_bus_if.ram bus,
    input  logic  write_enable
);
    import mem_stage_pkg::*;

    word_t mem [RAM_WORDS];

    // byte lane writes at the clock edge.
    always_ff @(posedge clk) begin
        if (write_enable) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (bus.lane_mask[lane]) begin
                    mem[bus.word_index][lane*8 +: 8] <= bus.write_data[lane*8 +: 8];
                end
            end
        end
    end

    // asynchronous read of the addressed word.
    assign bus.read_data = mem[bus.word_index];

endmodule

//--- src/mem_stage_top.sv
`timescale 1ns/1ps

module mem_stage_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      valid,
    input  mem_stage_pkg::mem_read_t  read_mode,
    input  mem_stage_pkg::mem_write_t write_mode,
    input  mem_stage_pkg::addr_t      addr,
    input  mem_stage_pkg::word_t      register_data,
    output mem_stage_pkg::word_t      load_data,
    output logic                      load_valid,
    output logic                      addr_error,
    output mem_stage_pkg::addr_t      bad_addr
);
    import mem_stage_pkg::*;

    word_t load_result;
    logic  misaligned;
    logic  write_enable;

    mem_bus_if u_mem_bus ();

    load_store_align u_load_store_align (
        .read_mode     (read_mode),
        .write_mode    (write_mode),
        .addr          (addr),
        .register_data (register_data),
        .bus           (u_mem_bus.align),
        .load_result   (load_result)
    );

    align_check u_align_check (
        .valid        (valid),
        .read_mode    (read_mode),
        .write_mode   (write_mode),
        .addr         (addr),
        .misaligned   (misaligned),
        .write_enable (write_enable)
    );

    data_ram u_data_ram (
        .clk          (clk),
        .bus          (u_mem_bus.ram),
        .write_enable (write_enable)
    );

    mem_writeback u_mem_writeback (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid       (valid),
        .read_mode   (read_mode),
        .addr        (addr),
        .load_result (load_result),
        .misaligned  (misaligned),
        .load_data   (load_data),
        .load_valid  (load_valid),
        .addr_error  (addr_error),
        .bad_addr    (bad_addr)
    );

endmodule

//--- src/mem_writeback.sv
`timescale 1ns/1ps

module mem_writeback (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     valid,
    input  mem_stage_pkg::mem_read_t read_mode,
    input  mem_stage_pkg::addr_t     addr,
    input  mem_stage_pkg::word_t     load_result,
    input  logic                     misaligned,
    output mem_stage_pkg::word_t     load_data,
    output logic                     load_valid,
    output logic                     addr_error,
    output mem_stage_pkg::addr_t     bad_addr
);
    import mem_stage_pkg::*;

    logic load_ok;
    logic fault;

    assign load_ok = valid & (read_mode != MEM_READ_NONE) & ~misaligned;
    assign fault   = valid & misaligned;

    // result flags, one cycle pulse each.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            load_valid <= 1'b0;
            addr_error <= 1'b0;
        end else begin
            load_valid <= load_ok;
            addr_error <= fault;
        end
    end

    // faulting address, held until the next error.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bad_addr <= '0;
        end else if (fault) begin
            bad_addr <= addr;
        end
    end

    // load data is only meaningful with load_valid.
    always_ff @(posedge clk) begin
        load_data <= load_result;
    end

endmodule

//--- tests/mem_stage_cases.svh
    // columns: name, read mode, write mode, address, register data,
    // expected load data, expected error flag.
    task automatic fill_case_table();
        // word store and load, then byte and half lanes inside one word.
        add_case("sw_word_00", MEM_READ_NONE, MEM_WRITE_WORD, 32'h00, 32'h11223344, 32'h0, 1'b0);
        add_case("lw_word_00", MEM_READ_WORD, MEM_WRITE_NONE, 32'h00, 32'h0, 32'h11223344, 1'b0);
        add_case("sw_word_08", MEM_READ_NONE, MEM_WRITE_WORD, 32'h08, 32'ha5b6c7d8, 32'h0, 1'b0);
        add_case("sb_lane1", MEM_READ_NONE, MEM_WRITE_BYTE, 32'h09, 32'h776655e1, 32'h0, 1'b0);
        add_case("sh_upper", MEM_READ_NONE, MEM_WRITE_HALF, 32'h0a, 32'h12348f70, 32'h0, 1'b0);
        add_case("lw_after_sub", MEM_READ_WORD, MEM_WRITE_NONE, 32'h08, 32'h0, 32'h8f70e1d8, 1'b0);
        add_case("lb_neg", MEM_READ_BYTE, MEM_WRITE_NONE, 32'h09, 32'h0, 32'hffffffe1, 1'b0);
        add_case("lbu_neg", MEM_READ_UNSIGN_BYTE, MEM_WRITE_NONE, 32'h09, 32'h0, 32'h000000e1, 1'b0);
        add_case("lb_pos", MEM_READ_BYTE, MEM_WRITE_NONE, 32'h0a, 32'h0, 32'h00000070, 1'b0);
        add_case("lh_neg", MEM_READ_HALF, MEM_WRITE_NONE, 32'h0a, 32'h0, 32'hffff8f70, 1'b0);
        add_case("lhu_neg", MEM_READ_UNSIGN_HALF, MEM_WRITE_NONE, 32'h0a, 32'h0, 32'h00008f70, 1'b0);
        add_case("lh_low", MEM_READ_HALF, MEM_WRITE_NONE, 32'h08, 32'h0, 32'hffffe1d8, 1'b0);
        // address bits above 7 are ignored.
        add_case("lw_wrap", MEM_READ_WORD, MEM_WRITE_NONE, 32'h108, 32'h0, 32'h8f70e1d8, 1'b0);
        // unaligned word loads merge into register data aabbccdd.
        add_case("sw_word_10", MEM_READ_NONE, MEM_WRITE_WORD, 32'h10, 32'h44332211, 32'h0, 1'b0);
        add_case("lwl_0", MEM_READ_LWL, MEM_WRITE_NONE, 32'h10, 32'haabbccdd, 32'h11bbccdd, 1'b0);
        add_case("lwl_1", MEM_READ_LWL, MEM_WRITE_NONE, 32'h11, 32'haabbccdd, 32'h2211ccdd, 1'b0);
        add_case("lwl_2", MEM_READ_LWL, MEM_WRITE_NONE, 32'h12, 32'haabbccdd, 32'h332211dd, 1'b0);
        add_case("lwl_3", MEM_READ_LWL, MEM_WRITE_NONE, 32'h13, 32'haabbccdd, 32'h44332211, 1'b0);
        add_case("lwr_0", MEM_READ_LWR, MEM_WRITE_NONE, 32'h10, 32'haabbccdd, 32'h44332211, 1'b0);
        add_case("lwr_1", MEM_READ_LWR, MEM_WRITE_NONE, 32'h11, 32'haabbccdd, 32'haa443322, 1'b0);
        add_case("lwr_2", MEM_READ_LWR, MEM_WRITE_NONE, 32'h12, 32'haabbccdd, 32'haabb4433, 1'b0);
        add_case("lwr_3", MEM_READ_LWR, MEM_WRITE_NONE, 32'h13, 32'haabbccdd, 32'haabbcc44, 1'b0);
        // swl and swr on a fresh word per offset.
        add_case("init_20", MEM_READ_NONE, MEM_WRITE_WORD, 32'h20, 32'h01020304, 32'h0, 1'b0);
        add_case("swl_0", MEM_READ_NONE, MEM_WRITE_SWL, 32'h20, 32'ha1b2c3d4, 32'h0, 1'b0);
        add_case("lw_swl_0", MEM_READ_WORD, MEM_WRITE_NONE, 32'h20, 32'h0, 32'h010203a1, 1'b0);
        add_case("swr_0", MEM_READ_NONE, MEM_WRITE_SWR, 32'h20, 32'h55667788, 32'h0, 1'b0);
        add_case("lw_swr_0", MEM_READ_WORD, MEM_WRITE_NONE, 32'h20, 32'h0, 32'h55667788, 1'b0);
        add_case("init_24", MEM_READ_NONE, MEM_WRITE_WORD, 32'h24, 32'h01020304, 32'h0, 1'b0);
        add_case("swl_1", MEM_READ_NONE, MEM_WRITE_SWL, 32'h25, 32'ha1b2c3d4, 32'h0, 1'b0);
        add_case("lw_swl_1", MEM_READ_WORD, MEM_WRITE_NONE, 32'h24, 32'h0, 32'h0102a1b2, 1'b0);
        add_case("swr_1", MEM_READ_NONE, MEM_WRITE_SWR, 32'h25, 32'h55667788, 32'h0, 1'b0);
        add_case("lw_swr_1", MEM_READ_WORD, MEM_WRITE_NONE, 32'h24, 32'h0, 32'h667788b2, 1'b0);
        add_case("init_28", MEM_READ_NONE, MEM_WRITE_WORD, 32'h28, 32'h01020304, 32'h0, 1'b0);
        add_case("swl_2", MEM_READ_NONE, MEM_WRITE_SWL, 32'h2a, 32'ha1b2c3d4, 32'h0, 1'b0);
        add_case("lw_swl_2", MEM_READ_WORD, MEM_WRITE_NONE, 32'h28, 32'h0, 32'h01a1b2c3, 1'b0);
        add_case("swr_2", MEM_READ_NONE, MEM_WRITE_SWR, 32'h2a, 32'h55667788, 32'h0, 1'b0);
        add_case("lw_swr_2", MEM_READ_WORD, MEM_WRITE_NONE, 32'h28, 32'h0, 32'h7788b2c3, 1'b0);
        add_case("init_2c", MEM_READ_NONE, MEM_WRITE_WORD, 32'h2c, 32'h01020304, 32'h0, 1'b0);
        add_case("swl_3", MEM_READ_NONE, MEM_WRITE_SWL, 32'h2f, 32'ha1b2c3d4, 32'h0, 1'b0);
        add_case("lw_swl_3", MEM_READ_WORD, MEM_WRITE_NONE, 32'h2c, 32'h0, 32'ha1b2c3d4, 1'b0);
        add_case("swr_3", MEM_READ_NONE, MEM_WRITE_SWR, 32'h2f, 32'h55667788, 32'h0, 1'b0);
        add_case("lw_swr_3", MEM_READ_WORD, MEM_WRITE_NONE, 32'h2c, 32'h0, 32'h88b2c3d4, 1'b0);
        // misaligned accesses fault and leave the ram alone.
        add_case("lh_odd", MEM_READ_HALF, MEM_WRITE_NONE, 32'h09, 32'h0, 32'h0, 1'b1);
        add_case("lhu_odd", MEM_READ_UNSIGN_HALF, MEM_WRITE_NONE, 32'h0b, 32'h0, 32'h0, 1'b1);
        add_case("lw_mis", MEM_READ_WORD, MEM_WRITE_NONE, 32'h8000010a, 32'h0, 32'h0, 1'b1);
        add_case("sh_odd", MEM_READ_NONE, MEM_WRITE_HALF, 32'h01, 32'hffffffff, 32'h0, 1'b1);
        add_case("sw_mis", MEM_READ_NONE, MEM_WRITE_WORD, 32'h03, 32'hdeadbeef, 32'h0, 1'b1);
        add_case("lw_unchanged", MEM_READ_WORD, MEM_WRITE_NONE, 32'h00, 32'h0, 32'h11223344, 1'b0);
    endtask

//--- tests/mem_stage_tb.sv
`timescale 1ns/1ps

module mem_stage_tb;
    import mem_stage_pkg::*;

    localparam int MAX_CASES    = 64;
    localparam int NUM_RANDOM   = 200;
    localparam int RESET_CYCLES = 8;
    // reset, table, ram fill and random requests plus a margin.
    localparam int CYCLE_LIMIT  = RESET_CYCLES + MAX_CASES + RAM_WORDS + NUM_RANDOM + 50;

    logic       clk;
    logic       rst_n;
    logic       valid;
    mem_read_t  read_mode;
    mem_write_t write_mode;
    addr_t      addr;
    word_t      register_data;
    word_t      load_data;
    logic       load_valid;
    logic       addr_error;
    addr_t      bad_addr;

    string      case_name [MAX_CASES];
    mem_read_t  case_read [MAX_CASES];
    mem_write_t case_write [MAX_CASES];
    addr_t      case_addr [MAX_CASES];
    word_t      case_reg [MAX_CASES];
    word_t      case_data [MAX_CASES];
    logic       case_err [MAX_CASES];
    int         num_cases;

    // request in flight is checked one cycle after issue.
    logic       pend_active;
    string      pend_name;
    logic       pend_load;
    logic       pend_err;
    word_t      pend_data;
    addr_t      pend_addr;

    // last faulting address that bad_addr should hold.
    addr_t      last_bad_addr;

    // reference byte image of the ram indexed by address bits 7 to 0.
    logic [7:0] ref_bytes [256];

    integer     seed;
    int         cycle_count;
    int         test_count;
    int         fail_count;
    logic       test_failed;

    mem_stage_top u_mem_stage_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .valid         (valid),
        .read_mode     (read_mode),
        .write_mode    (write_mode),
        .addr          (addr),
        .register_data (register_data),
        .load_data     (load_data),
        .load_valid    (load_valid),
        .addr_error    (addr_error),
        .bad_addr      (bad_addr)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic add_case(input string name, input mem_read_t rm, input mem_write_t wm,
                            input addr_t a, input word_t rd, input word_t exp_data,
                            input logic exp_err);
        case_name[num_cases]  = name;
        case_read[num_cases]  = rm;
        case_write[num_cases] = wm;
        case_addr[num_cases]  = a;
        case_reg[num_cases]   = rd;
        case_data[num_cases]  = exp_data;
        case_err[num_cases]   = exp_err;
        num_cases = num_cases + 1;
    endtask

    `include "mem_stage_cases.svh"

    // only the first wrong value of a test gets a line.
    task automatic report_mismatch(input string what, input word_t expected, input word_t actual);
        if (!test_failed) begin
            $display("Fail %s: %s expected %h actual %h", pend_name, what, expected, actual);
        end
        test_failed = 1'b1;
    endtask

    task automatic finish_test();
        if (test_failed) begin
            fail_count = fail_count + 1;
        end else begin
            $display("ok   %s", pend_name);
        end
    endtask

    task automatic check_reset();
        pend_name   = "reset_state";
        test_failed = 1'b0;
        test_count  = test_count + 1;
        if (load_valid !== 1'b0) begin
            report_mismatch("load_valid", 32'd0, word_t'(load_valid));
        end
        if (addr_error !== 1'b0) begin
            report_mismatch("addr_error", 32'd0, word_t'(addr_error));
        end
        if (bad_addr !== 32'd0) begin
            report_mismatch("bad_addr", 32'd0, bad_addr);
        end
        finish_test();
    endtask

    task automatic check_pending();
        if (pend_active) begin
            test_failed = 1'b0;
            test_count  = test_count + 1;
            if (pend_err) begin
                if (addr_error !== 1'b1) begin
                    report_mismatch("addr_error", 32'd1, word_t'(addr_error));
                end
                if (bad_addr !== pend_addr) begin
                    report_mismatch("bad_addr", pend_addr, bad_addr);
                end
                if (load_valid !== 1'b0) begin
                    report_mismatch("load_valid", 32'd0, word_t'(load_valid));
                end
                last_bad_addr = pend_addr;
            end else begin
                if (addr_error !== 1'b0) begin
                    report_mismatch("addr_error", 32'd0, word_t'(addr_error));
                end
                if (bad_addr !== last_bad_addr) begin
                    report_mismatch("bad_addr", last_bad_addr, bad_addr);
                end
                if (load_valid !== pend_load) begin
                    report_mismatch("load_valid", word_t'(pend_load), word_t'(load_valid));
                end
                if (pend_load && load_data !== pend_data) begin
                    report_mismatch("load_data", pend_data, load_data);
                end
            end
            finish_test();
            pend_active = 1'b0;
        end
    endtask

    // checks the previous request and then drives the next one.
    task automatic send_request(input string name, input logic req_valid, input mem_read_t rm,
                                input mem_write_t wm, input addr_t a, input word_t rd,
                                input word_t exp_data, input logic exp_err);
        @(negedge clk);
        check_pending();
        valid         = req_valid;
        read_mode     = rm;
        write_mode    = wm;
        addr          = a;
        register_data = rd;
        pend_active   = 1'b1;
        pend_name     = name;
        pend_load     = req_valid && (rm != MEM_READ_NONE);
        pend_err      = exp_err;
        pend_data     = exp_data;
        pend_addr     = a;
    endtask

    // half accesses need an even address and word accesses a multiple of four.
    function automatic logic is_misaligned(input mem_read_t rm, input mem_write_t wm,
                                           input addr_t a);
        logic half;
        logic word;
        half = (rm == MEM_READ_HALF) || (rm == MEM_READ_UNSIGN_HALF) || (wm == MEM_WRITE_HALF);
        word = (rm == MEM_READ_WORD) || (wm == MEM_WRITE_WORD);
        return (half && a[0]) || (word && (a[1:0] != 2'b00));
    endfunction

    task automatic model_store(input mem_write_t wm, input addr_t a, input word_t d);
        logic [7:0] base;
        case (wm)
            MEM_WRITE_BYTE: begin
                ref_bytes[a[7:0]] = d[7:0];
            end
            MEM_WRITE_HALF: begin
                base = {a[7:1], 1'b0};
                ref_bytes[base]        = d[7:0];
                ref_bytes[base | 8'd1] = d[15:8];
            end
            MEM_WRITE_WORD: begin
                base = {a[7:2], 2'b00};
                for (int i = 0; i < 4; i++) begin
                    ref_bytes[base | 8'(i)] = d[i*8 +: 8];
                end
            end
            default: ;
        endcase
    endtask

    function automatic word_t model_load(input mem_read_t rm, input addr_t a);
        logic [7:0]  b;
        logic [7:0]  hb;
        logic [7:0]  wb;
        logic [15:0] h;
        b  = ref_bytes[a[7:0]];
        hb = {a[7:1], 1'b0};
        wb = {a[7:2], 2'b00};
        h  = {ref_bytes[hb | 8'd1], ref_bytes[hb]};
        case (rm)
            MEM_READ_BYTE:        return {{24{b[7]}}, b};
            MEM_READ_UNSIGN_BYTE: return {24'd0, b};
            MEM_READ_HALF:        return {{16{h[15]}}, h};
            MEM_READ_UNSIGN_HALF: return {16'd0, h};
            MEM_READ_WORD:
                return {ref_bytes[wb | 8'd3], ref_bytes[wb | 8'd2],
                        ref_bytes[wb | 8'd1], ref_bytes[wb]};
            default:              return 32'd0;
        endcase
    endfunction

    task automatic fill_ram();
        addr_t a;
        word_t pattern;
        for (int i = 0; i < RAM_WORDS; i++) begin
            a = addr_t'(i * 4);
            pattern = {a[7:0] ^ 8'h5a, ~a[7:0], a[7:0] + 8'h3c, {a[3:0], a[7:4]}};
            model_store(MEM_WRITE_WORD, a, pattern);
            send_request($sformatf("fill_%0d", i), 1'b1, MEM_READ_NONE, MEM_WRITE_WORD, a,
                         pattern, 32'd0, 1'b0);
        end
    endtask

    task automatic run_random();
        word_t      r;
        mem_read_t  rm;
        mem_write_t wm;
        addr_t      a;
        word_t      d;
        word_t      expected;
        logic       err;
        logic       req_valid;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r  = $random(seed);
            a  = $random(seed);
            d  = $random(seed);
            rm = MEM_READ_NONE;
            wm = MEM_WRITE_NONE;
            // about half the requests land on a word boundary.
            if (r[3]) begin
                a[1:0] = 2'b00;
            end
            case (r[2:0])
                3'd0: wm = MEM_WRITE_BYTE;
                3'd1: wm = MEM_WRITE_HALF;
                3'd2: wm = MEM_WRITE_WORD;
                3'd3: rm = MEM_READ_BYTE;
                3'd4: rm = MEM_READ_UNSIGN_BYTE;
                3'd5: rm = MEM_READ_HALF;
                3'd6: rm = MEM_READ_UNSIGN_HALF;
                default: rm = MEM_READ_WORD;
            endcase
            // about one request in eight goes out with valid low and changes nothing.
            req_valid = (r[6:4] != 3'd0);
            err       = req_valid && is_misaligned(rm, wm, a);
            expected  = 32'd0;
            if (req_valid && !err) begin
                expected = model_load(rm, a);
                model_store(wm, a, d);
            end
            send_request($sformatf("rand_%0d", i), req_valid, rm, wm, a, d, expected, err);
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        valid         = 1'b0;
        read_mode     = MEM_READ_NONE;
        write_mode    = MEM_WRITE_NONE;
        addr          = '0;
        register_data = '0;
        seed          = 32'h7e847422;
        cycle_count   = 0;
        test_count    = 0;
        fail_count    = 0;
        test_failed   = 1'b0;
        pend_active   = 1'b0;
        last_bad_addr = '0;
        num_cases     = 0;
        fill_case_table();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_reset();
        for (int i = 0; i < num_cases; i++) begin
            send_request(case_name[i], 1'b1, case_read[i], case_write[i], case_addr[i],
                         case_reg[i], case_data[i], case_err[i]);
        end
        fill_ram();
        run_random();
        @(negedge clk);
        check_pending();
        valid      = 1'b0;
        read_mode  = MEM_READ_NONE;
        write_mode = MEM_WRITE_NONE;
        $display("tests run %0d, tests failed %0d", test_count, fail_count);
        if (fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
